// File: common/sram_test_pkg.sv
//##################################################
// packet layout is fixed at 61 bits, macro_sel on top
// geometries match the behavioural macros only
//##################################################
package sram_test_pkg;

   // host side widths
   localparam int ADDR_BITS      = 10;
   localparam int DATA_BITS      = 32;
   localparam int WMASK_BITS     = 4;
   localparam int NUM_MACROS     = 4;
   localparam int MACRO_SEL_BITS = 2;
   localparam int CMD_BITS       = 61;
   localparam int RESULT_BITS    = 64;

   // macro 0 and 1 are 1rw1r, macro 2 and 3 single port
   localparam int M0_DEPTH = 1024;
   localparam int M0_WIDTH = 8;
   localparam int M1_DEPTH = 256;
   localparam int M1_WIDTH = 32;
   localparam int M2_DEPTH = 512;
   localparam int M2_WIDTH = 32;
   localparam int M3_DEPTH = 512;
   localparam int M3_WIDTH = 64;

   // load strobe to result_valid_o
   localparam int LOAD_TO_RESULT = 3;

   // command packet, most significant field first
   typedef struct packed {
      logic [MACRO_SEL_BITS-1:0] macro_sel;
      logic                      csb0;
      logic                      web0;
      logic [WMASK_BITS-1:0]     wmask0;
      logic [ADDR_BITS-1:0]      addr0;
      logic [DATA_BITS-1:0]      din0;
      logic                      csb1;
      logic [ADDR_BITS-1:0]      addr1;
   } sram_cmd_t;

   // command as handed to the bank
   typedef struct packed {
      sram_cmd_t cmd;
      logic      valid;
   } sram_issue_t;

   // dout0 sits on top so it leaves the serial port first
   typedef struct packed {
      logic [DATA_BITS-1:0] dout0;
      logic [DATA_BITS-1:0] dout1;
   } sram_result_t;

endpackage

// File: compile.f
common/sram_test_pkg.sv
sram_bank/sram_macro_1rw1r.sv
sram_bank/sram_macro_1rw.sv
sram_bank/sram_bank.sv
hdl/cmd_loader.sv
hdl/result_unloader.sv
hdl/openram_test_top.sv
dv/openram_test_chk.sv
dv/openram_test_tb.sv

// File: dv/openram_test_chk.sv
//##################################################
// port checks on openram_test_top, bound from here
// fail_count is read by the testbench at the end
//##################################################
`timescale 1ns/1ps

module openram_test_chk (
   input  logic                        sram_clk,
   input  logic                        in_reset,
   input  logic                        sram_load_i,
   input  sram_test_pkg::sram_result_t la_result_o,
   input  logic                        result_valid_o,
   input  logic                        gpio_out_o
);

   int fail_count = 0;

   // fixed pipeline, no stalls
   result_latency: assert property (@(posedge sram_clk) disable iff (in_reset)
      result_valid_o == $past(sram_load_i, sram_test_pkg::LOAD_TO_RESULT))
   else begin
      $error("result_valid_o does not follow sram_load_i by the fixed latency");
      fail_count++;
   end

   // one reset edge is enough to clear the outputs
   reset_outputs: assert property (@(posedge sram_clk)
      in_reset && $past(in_reset) |-> (la_result_o == '0 && !result_valid_o && !gpio_out_o))
   else begin
      $error("outputs are not zero during reset");
      fail_count++;
   end

   gpio_known: assert property (@(posedge sram_clk) disable iff (in_reset)
      !$isunknown(gpio_out_o))
   else begin
      $error("gpio_out_o is unknown");
      fail_count++;
   end

endmodule

bind openram_test_top openram_test_chk openram_test_chk_inst (
   .sram_clk       (sram_clk),
   .in_reset       (in_reset),
   .sram_load_i    (sram_load_i),
   .la_result_o    (la_result_o),
   .result_valid_o (result_valid_o),
   .gpio_out_o     (gpio_out_o)
);

// File: dv/openram_test_tb.sv
//##################################################
// results are checked in issue order against a model
// macro contents start unknown, tests read only written words
//##################################################
`timescale 1ns/1ps

module openram_test_tb;

   // about 40 serial packets of 70 cycles, seven times over
   localparam int TIMEOUT_CYCLES = 20000;

   typedef struct packed {
      logic [sram_test_pkg::RESULT_BITS-1:0] value;
      logic [sram_test_pkg::RESULT_BITS-1:0] care;
   } expect_t;

   logic                        sram_clk;
   logic                        in_reset;
   logic                        in_select_i;
   logic                        gpio_in_i;
   logic                        gpio_scan_i;
   logic                        la_in_load_i;
   logic                        sram_load_i;
   sram_test_pkg::sram_cmd_t    la_cmd_i;
   sram_test_pkg::sram_result_t la_result_o;
   logic                        result_valid_o;
   logic                        gpio_out_o;

   // reference contents, host view of each macro
   logic [sram_test_pkg::M0_WIDTH-1:0]  ref0 [sram_test_pkg::M0_DEPTH];
   logic [sram_test_pkg::DATA_BITS-1:0] ref1 [sram_test_pkg::M1_DEPTH];
   logic [sram_test_pkg::DATA_BITS-1:0] ref2 [sram_test_pkg::M2_DEPTH];
   logic [sram_test_pkg::DATA_BITS-1:0] ref3 [sram_test_pkg::M3_DEPTH];
   // last read word per port, unknown until the first read
   logic [31:0] hold0 [4];
   logic [31:0] hold1 [4];
   logic        known0 [4];
   logic        known1 [4];

   expect_t                  exp_q [$];
   expect_t                  last_exp;
   expect_t                  got_exp;
   sram_test_pkg::sram_cmd_t burst_q [$];
   int                       errors = 0;
   int                       tests = 0;
   int                       failed_tests = 0;
   int                       test_start_errors = 0;
   int                       cycles = 0;
   int                       total_errors;
   logic [9:0]               a;
   logic [9:0]               b;
   sram_test_pkg::sram_cmd_t cmd_a;
   sram_test_pkg::sram_cmd_t cmd_b;

   openram_test_top openram_test_top_inst (
      .sram_clk       (sram_clk),
      .in_reset       (in_reset),
      .in_select_i    (in_select_i),
      .gpio_in_i      (gpio_in_i),
      .gpio_scan_i    (gpio_scan_i),
      .la_in_load_i   (la_in_load_i),
      .sram_load_i    (sram_load_i),
      .la_cmd_i       (la_cmd_i),
      .la_result_o    (la_result_o),
      .result_valid_o (result_valid_o),
      .gpio_out_o     (gpio_out_o)
   );

   always #2 sram_clk = ~sram_clk;

   function automatic void check_value(input string name, input logic [63:0] got,
                                       input logic [63:0] want);
      assert (got === want) else begin
         $display("error %0t %s expected %h got %h", $time, name, want, got);
         errors++;
      end
   endfunction

   function automatic logic [9:0] rand_addr();
      logic [31:0] r;
      r = $urandom();
      return r[9:0];
   endfunction

   // same word seen through the address bits above each depth
   function automatic logic [9:0] alias_addr(input int m, input logic [9:0] addr);
      case (m)
         1:       return addr ^ 10'h300;
         2, 3:    return addr ^ 10'h200;
         default: return addr;
      endcase
   endfunction

   function automatic sram_test_pkg::sram_cmd_t make_cmd(
      input logic [1:0] m, input logic csb0, input logic web0, input logic [3:0] mask,
      input logic [9:0] addr0, input logic [31:0] din, input logic csb1,
      input logic [9:0] addr1);
      sram_test_pkg::sram_cmd_t cmd;
      cmd.macro_sel = m;
      cmd.csb0      = csb0;
      cmd.web0      = web0;
      cmd.wmask0    = mask;
      cmd.addr0     = addr0;
      cmd.din0      = din;
      cmd.csb1      = csb1;
      cmd.addr1     = addr1;
      return cmd;
   endfunction

   function automatic sram_test_pkg::sram_cmd_t write_cmd(
      input logic [1:0] m, input logic [9:0] addr, input logic [31:0] din,
      input logic [3:0] mask);
      return make_cmd(m, 1'b0, 1'b0, mask, addr, din, 1'b1, 10'd0);
   endfunction

   function automatic sram_test_pkg::sram_cmd_t read_cmd(
      input logic [1:0] m, input logic [9:0] addr0, input logic [9:0] addr1);
      return make_cmd(m, 1'b0, 1'b1, 4'h0, addr0, 32'd0, 1'b0, addr1);
   endfunction

   function automatic logic [31:0] read_ref(input int m, input logic [9:0] addr);
      case (m)
         0:       return {24'd0, ref0[addr]};
         1:       return ref1[addr[7:0]];
         2:       return ref2[addr[8:0]];
         default: return ref3[addr[8:0]];
      endcase
   endfunction

   function automatic void store_ref(input int m, input logic [9:0] addr,
                                     input logic [31:0] word);
      case (m)
         0:       ref0[addr] = word[7:0];
         1:       ref1[addr[7:0]] = word;
         2:       ref2[addr[8:0]] = word;
         default: ref3[addr[8:0]] = word;
      endcase
   endfunction

   // model one issued command and queue its expected result
   function automatic void apply_ref(input sram_test_pkg::sram_cmd_t cmd);
      int          m;
      logic [31:0] w;
      expect_t     e;
      m = int'(cmd.macro_sel);
      // port 1 samples before the port 0 write lands
      if (!cmd.csb1 && m < 2) begin
         hold1[m]  = read_ref(m, cmd.addr1);
         known1[m] = 1'b1;
      end
      if (!cmd.csb0 && !cmd.web0) begin
         w = read_ref(m, cmd.addr0);
         for (int k = 0; k < 4; k++) begin
            if (cmd.wmask0[k]) begin
               w[k*8 +: 8] = cmd.din0[k*8 +: 8];
            end
         end
         store_ref(m, cmd.addr0, w);
      end else if (!cmd.csb0) begin
         hold0[m]  = read_ref(m, cmd.addr0);
         known0[m] = 1'b1;
      end
      e.value = {hold0[m], (m < 2) ? hold1[m] : 32'd0};
      e.care  = {known0[m] ? 32'hffff_ffff : 32'd0,
                 (m >= 2 || known1[m]) ? 32'hffff_ffff : 32'd0};
      exp_q.push_back(e);
   endfunction

   task automatic wait_results();
      while (exp_q.size() != 0) begin
         @(posedge sram_clk);
      end
   endtask

   // la loads pipelined with the issue, one command per cycle
   task automatic flush_burst();
      int n;
      n = burst_q.size();
      for (int i = 0; i <= n; i++) begin
         @(posedge sram_clk);
         in_select_i  <= 1'b0;
         gpio_scan_i  <= 1'b0;
         la_in_load_i <= (i < n);
         sram_load_i  <= (i > 0);
         if (i < n) begin
            la_cmd_i <= burst_q[i];
         end
         if (i > 0) begin
            apply_ref(burst_q[i-1]);
         end
      end
      @(posedge sram_clk);
      la_in_load_i <= 1'b0;
      sram_load_i  <= 1'b0;
      burst_q.delete();
      wait_results();
   endtask

   task automatic send_gpio(input sram_test_pkg::sram_cmd_t cmd);
      logic [63:0] shifted;
      for (int i = sram_test_pkg::CMD_BITS - 1; i >= 0; i--) begin
         @(posedge sram_clk);
         in_select_i  <= 1'b1;
         gpio_scan_i  <= 1'b1;
         gpio_in_i    <= cmd[i];
         // la side must be ignored in gpio mode
         la_in_load_i <= 1'b1;
         la_cmd_i     <= write_cmd(2'd2, rand_addr(), $urandom(), 4'hf);
      end
      @(posedge sram_clk);
      gpio_scan_i  <= 1'b0;
      la_in_load_i <= 1'b0;
      sram_load_i  <= 1'b1;
      apply_ref(cmd);
      @(posedge sram_clk);
      sram_load_i <= 1'b0;
      wait_results();
      // unload the captured result, msb first
      @(posedge sram_clk);
      gpio_scan_i <= 1'b1;
      for (int i = 63; i >= 0; i--) begin
         @(negedge sram_clk);
         shifted[i] = gpio_out_o;
      end
      @(posedge sram_clk);
      gpio_scan_i <= 1'b0;
      check_value("gpio_out_o", shifted & last_exp.care, last_exp.value & last_exp.care);
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (errors != test_start_errors) begin
         failed_tests++;
         $display("test %0d %s: failed, %0d errors", tests, name, errors - test_start_errors);
      end else begin
         $display("test %0d %s: ok", tests, name);
      end
      test_start_errors = errors;
   endtask

   // compare each result in issue order
   always @(posedge sram_clk) begin
      if (!in_reset && result_valid_o) begin
         if (exp_q.size() == 0) begin
            $display("result_valid_o pulsed at %0t with no command outstanding", $time);
            errors++;
         end else begin
            got_exp  = exp_q.pop_front();
            last_exp = got_exp;
            check_value("la_result_o", la_result_o & got_exp.care,
                        got_exp.value & got_exp.care);
         end
      end
   end

   always @(posedge sram_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout, run did not end within %0d cycles", TIMEOUT_CYCLES);
         $display("Finished with errors");
         $finish;
      end
   end

   initial begin
      void'($urandom(1595));
      sram_clk     = 1'b0;
      in_reset     = 1'b1;
      in_select_i  = 1'b0;
      gpio_in_i    = 1'b0;
      gpio_scan_i  = 1'b0;
      la_in_load_i = 1'b0;
      sram_load_i  = 1'b0;
      la_cmd_i     = '0;
      for (int m = 0; m < 4; m++) begin
         known0[m] = 1'b0;
         known1[m] = 1'b0;
      end
      repeat (8) @(posedge sram_clk);
      in_reset <= 1'b0;
      @(negedge sram_clk);
      check_value("la_result_o", la_result_o, 64'd0);
      check_value("result_valid_o", {63'd0, result_valid_o}, 64'd0);
      check_value("gpio_out_o", {63'd0, gpio_out_o}, 64'd0);
      finish_test("reset values");

      for (int m = 0; m < 4; m++) begin
         a = rand_addr();
         burst_q.push_back(write_cmd(2'(m), a, $urandom(), 4'hf));
         burst_q.push_back(read_cmd(2'(m), alias_addr(m, a), a));
      end
      flush_burst();
      finish_test("write then read");

      // macro 0 only reacts to mask bit 0
      for (int m = 0; m < 4; m++) begin
         a = rand_addr();
         burst_q.push_back(write_cmd(2'(m), a, $urandom(), 4'hf));
         burst_q.push_back(write_cmd(2'(m), a, $urandom(), 4'b0110));
         burst_q.push_back(read_cmd(2'(m), a, a));
         burst_q.push_back(write_cmd(2'(m), a, $urandom(), 4'b1001));
         burst_q.push_back(read_cmd(2'(m), a, a));
      end
      flush_burst();
      finish_test("write masks");

      // port 1 read during a port 0 write, then port 1 alone
      for (int m = 0; m < 4; m++) begin
         a = rand_addr();
         burst_q.push_back(write_cmd(2'(m), a, $urandom(), 4'hf));
         burst_q.push_back(make_cmd(2'(m), 1'b0, 1'b0, 4'hf, a, $urandom(), 1'b0, a));
         burst_q.push_back(make_cmd(2'(m), 1'b1, 1'b1, 4'h0, a, 32'd0, 1'b0, a));
         burst_q.push_back(read_cmd(2'(m), a, a));
      end
      flush_burst();
      finish_test("port 1 reads");

      a = rand_addr();
      cmd_a = write_cmd(2'd1, a, $urandom(), 4'hf);
      cmd_b = read_cmd(2'd1, a, a);
      send_gpio(cmd_a);
      send_gpio(cmd_b);
      burst_q.push_back(cmd_b);
      flush_burst();
      cmd_a = write_cmd(2'd3, a, $urandom(), 4'b1011);
      cmd_b = read_cmd(2'd3, a, a);
      send_gpio(cmd_a);
      send_gpio(cmd_b);
      burst_q.push_back(cmd_b);
      flush_burst();
      finish_test("gpio scan");

      a = rand_addr();
      b = a ^ 10'h001;
      for (int m = 0; m < 4; m++) begin
         burst_q.push_back(write_cmd(2'(m), a, $urandom(), 4'hf));
         burst_q.push_back(write_cmd(2'(m), b, $urandom(), 4'hf));
      end
      burst_q.push_back(write_cmd(2'd1, a, $urandom(), 4'hf));
      for (int m = 0; m < 4; m++) begin
         burst_q.push_back(read_cmd(2'(m), a, a));
      end
      // port 1 deselected, then both ports
      burst_q.push_back(make_cmd(2'd1, 1'b0, 1'b1, 4'h0, b, 32'd0, 1'b1, 10'd0));
      burst_q.push_back(make_cmd(2'd1, 1'b1, 1'b1, 4'h0, 10'd0, 32'd0, 1'b1, 10'd0));
      flush_burst();
      finish_test("macro isolation and hold");

      repeat (4) @(posedge sram_clk);
      total_errors = errors + openram_test_top_inst.openram_test_chk_inst.fail_count;
      $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, total_errors);
      if (total_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: hdl/cmd_loader.sv
//##################################################
// gpio scan shifts msb first, 61 cycles per packet
// unselected input source is ignored, no handshake
//##################################################
`timescale 1ns/1ps

module cmd_loader (
   input  logic                       sram_clk,
   input  logic                       in_reset,
   input  logic                       in_select_i,
   input  logic                       gpio_in_i,
   input  logic                       gpio_scan_i,
   input  logic                       la_in_load_i,
   input  sram_test_pkg::sram_cmd_t   la_cmd_i,
   input  logic                       sram_load_i,
   output sram_test_pkg::sram_issue_t issue_o
);

   // packet being assembled by the host
   sram_test_pkg::sram_cmd_t   cmd_q;
   sram_test_pkg::sram_issue_t issue_q;

   // next value of the command register when scanning
   logic [sram_test_pkg::CMD_BITS-1:0] cmd_shifted;

   assign cmd_shifted = {cmd_q[sram_test_pkg::CMD_BITS-2:0], gpio_in_i};

   // command register
   always_ff @(posedge sram_clk) begin
      if (in_reset) begin
         cmd_q <= '0;
      end else if (in_select_i) begin
         // gpio mode, new bit enters at the bottom
         if (gpio_scan_i) begin
            cmd_q <= sram_test_pkg::sram_cmd_t'(cmd_shifted);
         end
      end else begin
         // la mode, whole packet in one cycle
         if (la_in_load_i) begin
            cmd_q <= la_cmd_i;
         end
      end
   end

   // issue stage
   // valid is a single cycle pulse per load strobe, the packet
   // seen here is the one held before any shift in this cycle
   always_ff @(posedge sram_clk) begin
      if (in_reset) begin
         issue_q <= '0;
      end else begin
         issue_q.valid <= sram_load_i;
         if (sram_load_i) begin
            issue_q.cmd <= cmd_q;
         end
      end
   end

   assign issue_o = issue_q;

endmodule

// File: hdl/openram_test_top.sv
//##################################################
// single clock, sync active high reset
// load strobe to result takes three cycles
//##################################################
`timescale 1ns/1ps

module openram_test_top (
   input  logic                        sram_clk,
   input  logic                        in_reset,
   // host command side
   input  logic                        in_select_i,
   input  logic                        gpio_in_i,
   input  logic                        gpio_scan_i,
   input  logic                        la_in_load_i,
   input  logic                        sram_load_i,
   input  sram_test_pkg::sram_cmd_t    la_cmd_i,
   // results
   output sram_test_pkg::sram_result_t la_result_o,
   output logic                        result_valid_o,
   output logic                        gpio_out_o
);

   sram_test_pkg::sram_issue_t  issue;
   sram_test_pkg::sram_result_t rd;
   logic                        rd_valid;

   cmd_loader cmd_loader_inst (
      .sram_clk     (sram_clk),
      .in_reset     (in_reset),
      .in_select_i  (in_select_i),
      .gpio_in_i    (gpio_in_i),
      .gpio_scan_i  (gpio_scan_i),
      .la_in_load_i (la_in_load_i),
      .la_cmd_i     (la_cmd_i),
      .sram_load_i  (sram_load_i),
      .issue_o      (issue)
   );

   sram_bank sram_bank_inst (
      .sram_clk   (sram_clk),
      .in_reset   (in_reset),
      .issue_i    (issue),
      .rd_o       (rd),
      .rd_valid_o (rd_valid)
   );

   // shares gpio_scan_i with the loader
   result_unloader result_unloader_inst (
      .sram_clk       (sram_clk),
      .in_reset       (in_reset),
      .rd_i           (rd),
      .rd_valid_i     (rd_valid),
      .gpio_scan_i    (gpio_scan_i),
      .la_result_o    (la_result_o),
      .result_valid_o (result_valid_o),
      .gpio_out_o     (gpio_out_o)
   );

endmodule

// File: hdl/result_unloader.sv
//##################################################
// a new capture overwrites the serial register
// gpio_out_o gives bit 63 first, dout0 msb
//##################################################
`timescale 1ns/1ps

module result_unloader (
   input  logic                        sram_clk,
   input  logic                        in_reset,
   input  sram_test_pkg::sram_result_t rd_i,
   input  logic                        rd_valid_i,
   input  logic                        gpio_scan_i,
   output sram_test_pkg::sram_result_t la_result_o,
   output logic                        result_valid_o,
   output logic                        gpio_out_o
);

   sram_test_pkg::sram_result_t result_q;
   logic                        valid_q;

   // serial copy of the last result
   logic [sram_test_pkg::RESULT_BITS-1:0] shift_q;

   // parallel capture and one cycle pulse
   always_ff @(posedge sram_clk) begin
      if (in_reset) begin
         result_q <= '0;
         valid_q  <= 1'b0;
      end else begin
         valid_q <= rd_valid_i;
         if (rd_valid_i) begin
            result_q <= rd_i;
         end
      end
   end

   // reload wins over a scan in the same cycle
   always_ff @(posedge sram_clk) begin
      if (in_reset) begin
         shift_q <= '0;
      end else if (rd_valid_i) begin
         shift_q <= rd_i;
      end else if (gpio_scan_i) begin
         shift_q <= {shift_q[sram_test_pkg::RESULT_BITS-2:0], 1'b0};
      end
   end

   assign la_result_o    = result_q;
   assign result_valid_o = valid_q;
   assign gpio_out_o     = shift_q[sram_test_pkg::RESULT_BITS-1];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
# Exits non-zero on a build error, a simulator error or a failing run.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
   --top-module openram_test_tb \
   --Mdir "$BUILD_DIR" \
   -f compile.f
if [ $? -ne 0 ]; then
   echo "run_sim: verilator build failed"
   exit 1
fi

# keep running after an assertion error so the testbench can report
"./$BUILD_DIR/Vopenram_test_tb" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "run_sim: simulation exited with status $sim_status"
   exit 1
fi

if grep -Fxq "Finished with no errors" "$LOG_FILE"; then
   echo "run_sim: PASS"
   exit 0
else
   echo "run_sim: FAIL"
   exit 1
fi

// File: sram_bank/sram_bank.sv
//##################################################
// only the selected macro is enabled, others hold
// read words are valid one cycle after the issue
//##################################################
`timescale 1ns/1ps

module sram_bank (
   input  logic                        sram_clk,
   input  logic                        in_reset,
   input  sram_test_pkg::sram_issue_t  issue_i,
   output sram_test_pkg::sram_result_t rd_o,
   output logic                        rd_valid_o
);

   sram_test_pkg::sram_cmd_t cmd;

   // one-hot macro enable, chip selects derived from it
   logic [sram_test_pkg::NUM_MACROS-1:0] sel_vec;
   logic [sram_test_pkg::NUM_MACROS-1:0] csb0_vec;
   logic [sram_test_pkg::NUM_MACROS-1:0] csb1_vec;

   logic [sram_test_pkg::M0_WIDTH-1:0] m0_dout0;
   logic [sram_test_pkg::M0_WIDTH-1:0] m0_dout1;
   logic [sram_test_pkg::M1_WIDTH-1:0] m1_dout0;
   logic [sram_test_pkg::M1_WIDTH-1:0] m1_dout1;
   logic [sram_test_pkg::M2_WIDTH-1:0] m2_dout0;
   logic [sram_test_pkg::M3_WIDTH-1:0] m3_dout0;

   // macro 3 keeps host data in its outer 16-bit halves
   logic [sram_test_pkg::M3_WIDTH-1:0]   m3_din0;
   logic [sram_test_pkg::M3_WIDTH/8-1:0] m3_wmask0;

   // select and valid aligned with the macro read data
   logic [sram_test_pkg::MACRO_SEL_BITS-1:0] sel_q;
   logic                                     valid_q;

   assign cmd      = issue_i.cmd;
   assign sel_vec  = issue_i.valid ? (sram_test_pkg::NUM_MACROS'(1) << cmd.macro_sel) : '0;
   assign csb0_vec = ~(sel_vec & {sram_test_pkg::NUM_MACROS{~cmd.csb0}});
   assign csb1_vec = ~(sel_vec & {sram_test_pkg::NUM_MACROS{~cmd.csb1}});

   assign m3_din0   = {cmd.din0[31:16], 32'd0, cmd.din0[15:0]};
   assign m3_wmask0 = {cmd.wmask0[3:2], 4'b0000, cmd.wmask0[1:0]};

   // 8x1024, only mask bit 0 and the low byte reach it
   sram_macro_1rw1r #(
      .DEPTH (sram_test_pkg::M0_DEPTH),
      .WIDTH (sram_test_pkg::M0_WIDTH)
   ) sram0_inst (
      .sram_clk (sram_clk),
      .csb0_i   (csb0_vec[0]),
      .web0_i   (cmd.web0),
      .wmask0_i (cmd.wmask0[0]),
      .addr0_i  (cmd.addr0[$clog2(sram_test_pkg::M0_DEPTH)-1:0]),
      .din0_i   (cmd.din0[sram_test_pkg::M0_WIDTH-1:0]),
      .dout0_o  (m0_dout0),
      .csb1_i   (csb1_vec[0]),
      .addr1_i  (cmd.addr1[$clog2(sram_test_pkg::M0_DEPTH)-1:0]),
      .dout1_o  (m0_dout1)
   );

   // 32x256
   sram_macro_1rw1r #(
      .DEPTH (sram_test_pkg::M1_DEPTH),
      .WIDTH (sram_test_pkg::M1_WIDTH)
   ) sram1_inst (
      .sram_clk (sram_clk),
      .csb0_i   (csb0_vec[1]),
      .web0_i   (cmd.web0),
      .wmask0_i (cmd.wmask0),
      .addr0_i  (cmd.addr0[$clog2(sram_test_pkg::M1_DEPTH)-1:0]),
      .din0_i   (cmd.din0),
      .dout0_o  (m1_dout0),
      .csb1_i   (csb1_vec[1]),
      .addr1_i  (cmd.addr1[$clog2(sram_test_pkg::M1_DEPTH)-1:0]),
      .dout1_o  (m1_dout1)
   );

   // 32x512 single port
   sram_macro_1rw #(
      .DEPTH (sram_test_pkg::M2_DEPTH),
      .WIDTH (sram_test_pkg::M2_WIDTH)
   ) sram2_inst (
      .sram_clk (sram_clk),
      .csb0_i   (csb0_vec[2]),
      .web0_i   (cmd.web0),
      .wmask0_i (cmd.wmask0),
      .addr0_i  (cmd.addr0[$clog2(sram_test_pkg::M2_DEPTH)-1:0]),
      .din0_i   (cmd.din0),
      .dout0_o  (m2_dout0)
   );

   // 64x512 single port, middle bytes never written
   sram_macro_1rw #(
      .DEPTH (sram_test_pkg::M3_DEPTH),
      .WIDTH (sram_test_pkg::M3_WIDTH)
   ) sram3_inst (
      .sram_clk (sram_clk),
      .csb0_i   (csb0_vec[3]),
      .web0_i   (cmd.web0),
      .wmask0_i (m3_wmask0),
      .addr0_i  (cmd.addr0[$clog2(sram_test_pkg::M3_DEPTH)-1:0]),
      .din0_i   (m3_din0),
      .dout0_o  (m3_dout0)
   );

   always_ff @(posedge sram_clk) begin
      if (in_reset) begin
         sel_q   <= '0;
         valid_q <= 1'b0;
      end else begin
         sel_q   <= cmd.macro_sel;
         valid_q <= issue_i.valid;
      end
   end

   // read word select, single port macros read zero on dout1
   always_comb begin
      case (sel_q)
         2'd0: begin
            rd_o.dout0 = {{(sram_test_pkg::DATA_BITS - sram_test_pkg::M0_WIDTH){1'b0}}, m0_dout0};
            rd_o.dout1 = {{(sram_test_pkg::DATA_BITS - sram_test_pkg::M0_WIDTH){1'b0}}, m0_dout1};
         end
         2'd1: begin
            rd_o.dout0 = m1_dout0;
            rd_o.dout1 = m1_dout1;
         end
         2'd2: begin
            rd_o.dout0 = m2_dout0;
            rd_o.dout1 = '0;
         end
         default: begin
            rd_o.dout0 = {m3_dout0[63:48], m3_dout0[15:0]};
            rd_o.dout1 = '0;
         end
      endcase
   end

   assign rd_valid_o = valid_q;

endmodule

// File: sram_bank/sram_macro_1rw.sv
//##################################################
// behavioural single port model without reset
// dout0 holds during writes and while deselected
//##################################################
`timescale 1ns/1ps

module sram_macro_1rw #(
   parameter int DEPTH = 512,
   parameter int WIDTH = 32
) (
   input  logic                     sram_clk,
   input  logic                     csb0_i,
   input  logic                     web0_i,
   input  logic [WIDTH/8-1:0]       wmask0_i,
   input  logic [$clog2(DEPTH)-1:0] addr0_i,
   input  logic [WIDTH-1:0]         din0_i,
   output logic [WIDTH-1:0]         dout0_o
);

   logic [WIDTH-1:0] mem [DEPTH];

   always_ff @(posedge sram_clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            // one mask bit per byte lane
            for (int b = 0; b < WIDTH / 8; b++) begin
               if (wmask0_i[b]) begin
                  mem[addr0_i][b*8 +: 8] <= din0_i[b*8 +: 8];
               end
            end
         end else begin
            dout0_o <= mem[addr0_i];
         end
      end
   end

endmodule

// File: sram_bank/sram_macro_1rw1r.sv
//##################################################
// behavioural model, no reset, contents start unknown
// port 1 sees old data on a same-address write
//##################################################
`timescale 1ns/1ps

module sram_macro_1rw1r #(
   parameter int DEPTH = 1024,
   parameter int WIDTH = 8
) (
   input  logic                     sram_clk,
   // read-write port
   input  logic                     csb0_i,
   input  logic                     web0_i,
   input  logic [WIDTH/8-1:0]       wmask0_i,
   input  logic [$clog2(DEPTH)-1:0] addr0_i,
   input  logic [WIDTH-1:0]         din0_i,
   output logic [WIDTH-1:0]         dout0_o,
   // read-only port
   input  logic                     csb1_i,
   input  logic [$clog2(DEPTH)-1:0] addr1_i,
   output logic [WIDTH-1:0]         dout1_o
);

   logic [WIDTH-1:0] mem [DEPTH];

   // port 0, byte masked write or registered read
   always_ff @(posedge sram_clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            for (int b = 0; b < WIDTH / 8; b++) begin
               if (wmask0_i[b]) begin
                  mem[addr0_i][b*8 +: 8] <= din0_i[b*8 +: 8];
               end
            end
         end else begin
            dout0_o <= mem[addr0_i];
         end
      end
   end

   // port 1, holds while deselected
   always_ff @(posedge sram_clk) begin
      if (!csb1_i) begin
         dout1_o <= mem[addr1_i];
      end
   end

endmodule
